//--- Makefile
TOP = fpga_io_shell_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f fpga_io_shell.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/fpga_io_shell_chk.sv
// Assertions on the credit link, busy length and trigger gating.
// Bound into fpga_io_shell; ports reach into the sampler and engine.
`timescale 1ns/1ps

module fpga_io_shell_chk #(
  parameter int NumRounds = 8,
  parameter int FifoDepth = 2,
  parameter int CntW      = $clog2(FifoDepth + 1)
) (
  input logic            clk_i,
  input logic            rst_n_i,
  input logic            cmd_valid_i,
  input logic [CntW-1:0] credit_cnt_i,
  input logic            busy_i,
  input logic            trig_pad_i,
  input logic            busy_pad_i
);

  ////////////////////
  // Credit link
  ////////////////////

  credit_nonzero_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cmd_valid_i |-> (credit_cnt_i != '0))
    else $error("cmd_valid fired with zero credits");

  credit_bound_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      credit_cnt_i <= CntW'(FifoDepth))
    else $error("credit count above FIFO depth");

  ////////////////////
  // Engine activity
  ////////////////////

  // On the falling edge busy was high NumRounds cycles back, low one before
  busy_len_min_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $fell(busy_i) |-> $past(busy_i, NumRounds))
    else $error("busy shorter than NumRounds cycles");

  busy_len_max_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $fell(busy_i) |-> !$past(busy_i, NumRounds + 1))
    else $error("busy longer than NumRounds cycles");

  trig_gated_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      trig_pad_i |-> busy_pad_i)
    else $error("trigger pad high outside busy window");

endmodule : fpga_io_shell_chk

//--- dv/fpga_io_shell_tb.sv
// Self-checking testbench for the default NumRounds and FifoDepth.
// Pads change on the falling edge; outputs are sampled there as well.
`timescale 1ns/1ps

module fpga_io_shell_tb
  import io_shell_pkg::*;
();

  localparam int NumRounds = 8;
  localparam int FifoDepth = 2;
  localparam int Timeout   = 60;

  typedef struct packed {
    shell_op_e  op;
    logic [7:0] data;
    logic [7:0] exp_result;
    logic       exp_trig;
  } test_entry_t;

  logic               clk_main;
  logic               rst_n;
  logic               soft_rst;
  logic [NumPads-1:0] pad_in;
  logic [NumPads-1:0] pad_out;
  logic [NumPads-1:0] pad_oe;
  logic               jtag_tck;
  logic               jtag_tms;
  logic               jtag_tdi;
  logic               jtag_trst_n;
  logic               jtag_tdo;

  test_entry_t tests[$];
  int          seed = 32'h2937;
  int          err_cnt;
  int          test_errs;
  int          test_cnt;
  int          fail_cnt;
  logic        trig_seen;
  // Reference model state
  logic [7:0]  m_key;
  logic [7:0]  m_result;
  logic        m_trig;

  tb_clkgen u_clkgen (
    .soft_rst_i (soft_rst),
    .clk_o      (clk_main),
    .rst_n_o    (rst_n)
  );

  fpga_io_shell #(
    .NumRounds (NumRounds),
    .FifoDepth (FifoDepth)
  ) uut (
    .clk_main_i    (clk_main),
    .rst_n_i       (rst_n),
    .pad_in_i      (pad_in),
    .pad_out_o     (pad_out),
    .pad_oe_o      (pad_oe),
    .jtag_tck_o    (jtag_tck),
    .jtag_tms_o    (jtag_tms),
    .jtag_tdi_o    (jtag_tdi),
    .jtag_trst_n_o (jtag_trst_n),
    .jtag_tdo_i    (jtag_tdo)
  );

  bind fpga_io_shell fpga_io_shell_chk #(
    .NumRounds (NumRounds),
    .FifoDepth (FifoDepth)
  ) u_chk (
    .clk_i        (clk_main_i),
    .rst_n_i      (rst_n_i),
    .cmd_valid_i  (cmd_valid),
    .credit_cnt_i (u_sampler.credit_cnt_q),
    .busy_i       (busy),
    .trig_pad_i   (core_out[PadTrigger]),
    .busy_pad_i   (core_out[PadBusy])
  );

  ////////////////////
  // Reference model
  ////////////////////

  // Each round: XOR with key, then rotate left by one
  function automatic logic [7:0] scramble_model(logic [7:0] data, logic [7:0] key);
    logic [7:0] s;
    s = data;
    for (int i = 0; i < NumRounds; i++) begin
      s = s ^ key;
      s = {s[6:0], s[7]};
    end
    return s;
  endfunction

  function automatic logic [7:0] rand_byte();
    return 8'($random(seed));
  endfunction

  task automatic add_entry(input shell_op_e op, input logic [7:0] data);
    test_entry_t e;
    e.op       = op;
    e.data     = data;
    e.exp_trig = 1'b0;
    case (op)
      OP_ARM: m_trig = ~m_trig;
      OP_KEY: m_key = data;
      OP_SCRAMBLE: begin
        m_result   = scramble_model(data, m_key);
        e.exp_trig = m_trig;
      end
      default: begin
        m_key      = '0;
        m_result   = '0;
        e.exp_trig = m_trig;
      end
    endcase
    e.exp_result = m_result;
    tests.push_back(e);
  endtask

  ////////////////////
  // Checks and pad helpers
  ////////////////////

  task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED t=%0t: %s is %0h, expected %0h", $time, what, got, exp);
      test_errs++;
    end
  endtask

  task automatic timeout_error(input string what);
    $display("ERROR t=%0t: timed out waiting for %s", $time, what);
    test_errs++;
  endtask

  // One clock; trigger may only show inside the busy window
  task automatic sample_cycle();
    @(negedge clk_main);
    assert (!(pad_out[PadTrigger] && !pad_out[PadBusy])) else begin
      $display("FAILED t=%0t: trigger pad high while busy pad is low", $time);
      test_errs++;
    end
    if (pad_out[PadTrigger]) begin
      trig_seen = 1'b1;
    end
  endtask

  // Start held high for 2 cycles with opcode and data stable
  task automatic pulse_start(input shell_op_e op, input logic [7:0] data);
    pad_in[PadOp +: 2]   = op;
    pad_in[PadData +: 8] = data;
    pad_in[PadStart]     = 1'b1;
    sample_cycle();
    sample_cycle();
    pad_in[PadStart] = 1'b0;
  endtask

  task automatic wait_busy(input logic level);
    int n;
    n = 0;
    while (pad_out[PadBusy] !== level && n < Timeout) begin
      sample_cycle();
      n++;
    end
    if (pad_out[PadBusy] !== level) begin
      timeout_error(level ? "busy pad to rise" : "busy pad to fall");
    end
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (test_errs != 0) begin
      fail_cnt++;
    end
    err_cnt += test_errs;
    $display("test %0d %s: %s", test_cnt, name, (test_errs == 0) ? "passed" : "failed");
    test_errs = 0;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic apply_entry(input test_entry_t e);
    trig_seen = 1'b0;
    pulse_start(e.op, e.data);
    if (e.op == OP_SCRAMBLE || e.op == OP_CLEAR) begin
      wait_busy(1'b1);
      wait_busy(1'b0);
    end else begin
      repeat (6) sample_cycle();
    end
    expect_eq("result pads", pad_out[PadData +: 8], e.exp_result);
    expect_eq("trigger seen", trig_seen, e.exp_trig);
  endtask

  // Start edges while a scramble runs run out of credits
  task automatic drive_overflow();
    int n;
    int quiet;
    pulse_start(OP_SCRAMBLE, rand_byte());
    wait_busy(1'b1);
    repeat (6) begin
      pulse_start(OP_SCRAMBLE, rand_byte());
      sample_cycle();
      sample_cycle();
    end
    n     = 0;
    quiet = 0;
    while (quiet < 12 && n < 200) begin
      sample_cycle();
      quiet = pad_out[PadBusy] ? 0 : quiet + 1;
      n++;
    end
    if (quiet < 12) begin
      timeout_error("the engine to drain its queue");
    end
    expect_eq("overflow pad before reset", pad_out[PadOverflow], 1'b1);
    soft_rst = 1'b1;
    repeat (5) sample_cycle();
    soft_rst = 1'b0;
    sample_cycle();
    sample_cycle();
    expect_eq("overflow pad after reset", pad_out[PadOverflow], 1'b0);
  endtask

  task automatic check_jtag_overlay();
    logic [4:0] bits;
    logic [7:0] d;
    pad_in           = '0;
    pad_in[PadTrstN] = 1'b1;
    sample_cycle();
    // Data, busy, overflow and trigger pads are the only outputs
    expect_eq("pad_oe with strap low", pad_oe, 24'h0098ff);
    expect_eq("jtag_trst_n_o with strap low", jtag_trst_n, 1'b0);
    pad_in[PadJtagEn] = 1'b1;
    repeat (4) begin
      bits = 5'($random(seed));
      pad_in[PadTck]   = bits[0];
      pad_in[PadTms]   = bits[1];
      pad_in[PadTdi]   = bits[2];
      pad_in[PadTrstN] = bits[4];
      jtag_tdo         = bits[3];
      sample_cycle();
      expect_eq("jtag_tck_o", jtag_tck, bits[0]);
      expect_eq("jtag_tms_o", jtag_tms, bits[1]);
      expect_eq("jtag_tdi_o", jtag_tdi, bits[2]);
      expect_eq("jtag_trst_n_o", jtag_trst_n, bits[4]);
      expect_eq("TDO pad value", pad_out[PadTdo], jtag_tdo);
      expect_eq("TDO pad enable", pad_oe[PadTdo], 1'b1);
      expect_eq("TCK pad enable", pad_oe[PadTck], 1'b0);
    end
    // Key is zero again after the reset above
    d = rand_byte();
    pulse_start(OP_SCRAMBLE, d);
    wait_busy(1'b1);
    wait_busy(1'b0);
    expect_eq("result pads with strap high", pad_out[PadData +: 8], scramble_model(d, 8'h00));
    pad_in[PadJtagEn] = 1'b0;
    pad_in[PadTrstN]  = 1'b1;
    sample_cycle();
    expect_eq("jtag_trst_n_o after strap low", jtag_trst_n, 1'b0);
  endtask

  initial begin
    int n;
    pad_in    = '0;
    jtag_tdo  = 1'b0;
    soft_rst  = 1'b0;
    err_cnt   = 0;
    test_errs = 0;
    test_cnt  = 0;
    fail_cnt  = 0;
    trig_seen = 1'b0;
    m_key     = '0;
    m_result  = '0;
    m_trig    = 1'b0;

    n = 0;
    while (rst_n !== 1'b1 && n < 20) begin
      @(negedge clk_main);
      n++;
    end
    if (rst_n !== 1'b1) begin
      timeout_error("reset release");
    end
    sample_cycle();

    // Key then scramble, then trigger arming, then clear
    repeat (3) begin
      add_entry(OP_KEY, rand_byte());
      add_entry(OP_SCRAMBLE, rand_byte());
    end
    add_entry(OP_ARM, 8'h00);
    add_entry(OP_SCRAMBLE, rand_byte());
    add_entry(OP_ARM, 8'h00);
    add_entry(OP_SCRAMBLE, rand_byte());
    add_entry(OP_CLEAR, rand_byte());
    add_entry(OP_SCRAMBLE, rand_byte());

    foreach (tests[i]) begin
      apply_entry(tests[i]);
      end_test($sformatf("%s data=%02h", tests[i].op.name(), tests[i].data));
    end
    drive_overflow();
    end_test("overflow");
    check_jtag_overlay();
    end_test("jtag overlay");

    $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : fpga_io_shell_tb

//--- dv/tb_clkgen.sv
// Free-running 10 ns clock with reset held for the first 5 cycles.
// soft_rst_i pulls reset low again at any time, asynchronously.
`timescale 1ns/1ps

module tb_clkgen (
  input  logic soft_rst_i,
  output logic clk_o,
  output logic rst_n_o
);

  logic por_n;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Power-on reset, released on a falling edge
  initial begin
    por_n = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    por_n = 1'b1;
  end

  assign rst_n_o = por_n & ~soft_rst_i;

endmodule : tb_clkgen

//--- fpga_io_shell.f
source/io_shell_pkg.sv
source/jtag_overlay_mux.sv
source/pad_sampler.sv
source/scramble_engine.sv
source/pad_driver.sv
source/fpga_io_shell.sv
dv/tb_clkgen.sv
dv/fpga_io_shell_chk.sv
dv/fpga_io_shell_tb.sv

//--- source/fpga_io_shell.sv
// Single clock domain on clk_main_i; no PLL or pad cells here.
// Pads are split into separate in, out and output enable vectors.
`timescale 1ns/1ps

module fpga_io_shell
  import io_shell_pkg::*;
#(
  parameter int NumRounds = 8,
  parameter int FifoDepth = 2
) (
  input  logic               clk_main_i,
  input  logic               rst_n_i,

  // Pad side
  input  logic [NumPads-1:0] pad_in_i,
  output logic [NumPads-1:0] pad_out_o,
  output logic [NumPads-1:0] pad_oe_o,

  // External debug block
  output logic               jtag_tck_o,
  output logic               jtag_tms_o,
  output logic               jtag_tdi_o,
  output logic               jtag_trst_n_o,
  input  logic               jtag_tdo_i
);

  logic [NumPads-1:0] core_in;
  logic [NumPads-1:0] core_out;
  logic [NumPads-1:0] core_oe;

  shell_cmd_t    cmd;
  logic          cmd_valid;
  logic          credit_return;
  logic          overflow;
  logic [7:0]    result;
  logic          busy;
  logic          trig_req;
  shell_status_t status;

  ////////////////////
  // JTAG overlay
  ////////////////////

  jtag_overlay_mux u_jtag_mux (
    .pad_in_i      (pad_in_i),
    .core_out_i    (core_out),
    .core_oe_i     (core_oe),
    .jtag_tdo_i    (jtag_tdo_i),
    .core_in_o     (core_in),
    .pad_out_o     (pad_out_o),
    .pad_oe_o      (pad_oe_o),
    .jtag_tck_o    (jtag_tck_o),
    .jtag_tms_o    (jtag_tms_o),
    .jtag_tdi_o    (jtag_tdi_o),
    .jtag_trst_n_o (jtag_trst_n_o)
  );

  ////////////////////
  // Core
  ////////////////////

  pad_sampler #(
    .FifoDepth (FifoDepth)
  ) u_sampler (
    .clk_main_i      (clk_main_i),
    .rst_n_i         (rst_n_i),
    .core_in_i       (core_in),
    .credit_return_i (credit_return),
    .cmd_o           (cmd),
    .cmd_valid_o     (cmd_valid),
    .overflow_o      (overflow)
  );

  scramble_engine #(
    .NumRounds (NumRounds),
    .FifoDepth (FifoDepth)
  ) u_engine (
    .clk_main_i      (clk_main_i),
    .rst_n_i         (rst_n_i),
    .cmd_i           (cmd),
    .cmd_valid_i     (cmd_valid),
    .credit_return_o (credit_return),
    .result_o        (result),
    .busy_o          (busy),
    .trig_req_o      (trig_req)
  );

  // Overflow comes from the input side, the rest from the engine
  assign status = '{result: result, busy: busy, trig_req: trig_req, overflow: overflow};

  pad_driver u_driver (
    .clk_main_i (clk_main_i),
    .rst_n_i    (rst_n_i),
    .status_i   (status),
    .core_out_o (core_out),
    .core_oe_o  (core_oe)
  );

endmodule : fpga_io_shell

//--- source/io_shell_pkg.sv
// Pad map, opcodes and link types shared by the I/O shell.
// The map assumes a single 24-pad bank with JTAG on pads 16 to 21.
package io_shell_pkg;

  ////////////////////
  // Pad map
  ////////////////////

  parameter int NumPads = 24;

  // Base index of the 8 data pads, also used for the result
  parameter int PadData     = 0;
  // Base index of the 2 opcode pads
  parameter int PadOp       = 8;
  parameter int PadStart    = 10;
  parameter int PadBusy     = 11;
  parameter int PadOverflow = 12;
  parameter int PadTrigger  = 15;

  // JTAG overlay strap and pins
  parameter int PadJtagEn   = 16;
  parameter int PadTck      = 17;
  parameter int PadTms      = 18;
  parameter int PadTdi      = 19;
  parameter int PadTdo      = 20;
  parameter int PadTrstN    = 21;

  // Core view of the JTAG pads while the overlay is active
  // TMS and TRST_N idle high
  parameter logic [NumPads-1:0] TieOffValues =
      (NumPads'(1) << PadTms) | (NumPads'(1) << PadTrstN);

  ////////////////////
  // Link types
  ////////////////////

  typedef enum logic [1:0] {
    OP_ARM      = 2'd0,
    OP_KEY      = 2'd1,
    OP_SCRAMBLE = 2'd2,
    OP_CLEAR    = 2'd3
  } shell_op_e;

  typedef struct packed {
    shell_op_e  op;
    logic [7:0] data;
  } shell_cmd_t;

  typedef struct packed {
    logic [7:0] result;
    logic       busy;
    logic       trig_req;
    logic       overflow;
  } shell_status_t;

endpackage : io_shell_pkg

//--- source/jtag_overlay_mux.sv
// Purely combinational. The strap is taken straight from the pad,
// so it should only change while the core is held in reset.
`timescale 1ns/1ps

module jtag_overlay_mux
  import io_shell_pkg::*;
(
  input  logic [NumPads-1:0] pad_in_i,
  input  logic [NumPads-1:0] core_out_i,
  input  logic [NumPads-1:0] core_oe_i,
  input  logic               jtag_tdo_i,

  output logic [NumPads-1:0] core_in_o,
  output logic [NumPads-1:0] pad_out_o,
  output logic [NumPads-1:0] pad_oe_o,
  output logic               jtag_tck_o,
  output logic               jtag_tms_o,
  output logic               jtag_tdi_o,
  output logic               jtag_trst_n_o
);

  // Pads taken over by the overlay
  localparam logic [NumPads-1:0] JtagMask =
      (NumPads'(1) << PadTck)  |
      (NumPads'(1) << PadTms)  |
      (NumPads'(1) << PadTdi)  |
      (NumPads'(1) << PadTdo)  |
      (NumPads'(1) << PadTrstN);

  localparam logic [NumPads-1:0] TdoMask = NumPads'(1) << PadTdo;

  logic jtag_en;

  assign jtag_en = pad_in_i[PadJtagEn];

  ////////////////////
  // Debug side
  ////////////////////

  // Debug block stays in reset while the strap is low
  assign jtag_tck_o    = jtag_en & pad_in_i[PadTck];
  assign jtag_tms_o    = jtag_en & pad_in_i[PadTms];
  assign jtag_tdi_o    = jtag_en & pad_in_i[PadTdi];
  assign jtag_trst_n_o = jtag_en & pad_in_i[PadTrstN];

  ////////////////////
  // Core side
  ////////////////////

  always_comb begin
    core_in_o = pad_in_i;
    pad_out_o = core_out_i;
    pad_oe_o  = core_oe_i;

    if (jtag_en) begin
      // Core sees idle JTAG levels on the overlaid pads
      core_in_o = (pad_in_i & ~JtagMask) | (TieOffValues & JtagMask);

      // Only TDO is driven, the other JTAG pads are inputs
      pad_out_o = (core_out_i & ~JtagMask) | (jtag_tdo_i ? TdoMask : '0);
      pad_oe_o  = (core_oe_i & ~JtagMask) | TdoMask;
    end
  end

endmodule : jtag_overlay_mux

//--- source/pad_driver.sv
// One register stage from core status to pads.
// Output enables are fixed, the driven pads never turn around.
`timescale 1ns/1ps

module pad_driver
  import io_shell_pkg::*;
(
  input  logic               clk_main_i,
  input  logic               rst_n_i,
  input  shell_status_t      status_i,

  output logic [NumPads-1:0] core_out_o,
  output logic [NumPads-1:0] core_oe_o
);

  // Result, busy, overflow and trigger pads
  localparam logic [NumPads-1:0] DrivenMask =
      (NumPads'(8'hff) << PadData)    |
      (NumPads'(1) << PadBusy)        |
      (NumPads'(1) << PadOverflow)    |
      (NumPads'(1) << PadTrigger);

  shell_status_t status_d;
  shell_status_t status_q;

  // Trigger only leaves the chip while the engine is working,
  // which keeps the scope capture window tight
  always_comb begin
    status_d          = status_i;
    status_d.trig_req = status_i.trig_req & status_i.busy;
  end

  always_ff @(posedge clk_main_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      status_q <= '0;
    end else begin
      status_q <= status_d;
    end
  end

  ////////////////////
  // Pad mapping
  ////////////////////

  always_comb begin
    core_out_o                = '0;
    core_out_o[PadData +: 8]  = status_q.result;
    core_out_o[PadBusy]       = status_q.busy;
    core_out_o[PadOverflow]   = status_q.overflow;
    core_out_o[PadTrigger]    = status_q.trig_req;
  end

  assign core_oe_o = DrivenMask;

endmodule : pad_driver

//--- source/pad_sampler.sv
// Pads cannot be stalled. A start edge without credit is dropped and
// raises a sticky overflow that only reset clears.
`timescale 1ns/1ps

module pad_sampler
  import io_shell_pkg::*;
#(
  parameter int FifoDepth = 2
) (
  input  logic               clk_main_i,
  input  logic               rst_n_i,
  input  logic [NumPads-1:0] core_in_i,
  input  logic               credit_return_i,

  output shell_cmd_t         cmd_o,
  output logic               cmd_valid_o,
  output logic               overflow_o
);

  // Data, opcode and start pads are synchronized together
  localparam int SyncW = PadStart + 1;
  localparam int CntW  = $clog2(FifoDepth + 1);

  logic [SyncW-1:0] sync1_q;
  logic [SyncW-1:0] sync2_q;
  logic             start_prev_q;
  logic             start_edge;
  logic             issue;
  logic [CntW-1:0]  credit_cnt_q;
  shell_cmd_t       cmd_q;
  logic             cmd_valid_q;
  logic             overflow_q;

  ////////////////////
  // Synchronizer
  ////////////////////

  always_ff @(posedge clk_main_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q      <= '0;
      sync2_q      <= '0;
      start_prev_q <= 1'b0;
    end else begin
      sync1_q      <= core_in_i[SyncW-1:0];
      sync2_q      <= sync1_q;
      start_prev_q <= sync2_q[PadStart];
    end
  end

  assign start_edge = sync2_q[PadStart] & ~start_prev_q;

  // A credit spent by the command now on the link is not available
  assign issue = start_edge & (credit_cnt_q > CntW'(cmd_valid_q));

  ////////////////////
  // Credits
  ////////////////////

  always_ff @(posedge clk_main_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_cnt_q <= CntW'(FifoDepth);
      cmd_valid_q  <= 1'b0;
      overflow_q   <= 1'b0;
    end else begin
      cmd_valid_q <= issue;
      if (start_edge && !issue) begin
        overflow_q <= 1'b1;
      end
      case ({cmd_valid_q, credit_return_i})
        2'b10:   credit_cnt_q <= credit_cnt_q - 1'b1;
        2'b01:   credit_cnt_q <= credit_cnt_q + 1'b1;
        default: credit_cnt_q <= credit_cnt_q;
      endcase
    end
  end

  // Command word, only meaningful with cmd_valid_o
  always_ff @(posedge clk_main_i) begin
    if (start_edge) begin
      cmd_q.op   <= shell_op_e'(sync2_q[PadOp +: 2]);
      cmd_q.data <= sync2_q[PadData +: 8];
    end
  end

  assign cmd_o       = cmd_q;
  assign cmd_valid_o = cmd_valid_q;
  assign overflow_o  = overflow_q;

endmodule : pad_sampler

//--- source/scramble_engine.sv
// Stand-in for a cipher core, not cryptographically meaningful.
// Writes are never refused; the sender must respect its credits.
`timescale 1ns/1ps

module scramble_engine
  import io_shell_pkg::*;
#(
  parameter int NumRounds = 8,
  parameter int FifoDepth = 2
) (
  input  logic       clk_main_i,
  input  logic       rst_n_i,
  input  shell_cmd_t cmd_i,
  input  logic       cmd_valid_i,

  output logic       credit_return_o,
  output logic [7:0] result_o,
  output logic       busy_o,
  output logic       trig_req_o
);

  localparam int PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int CntW = $clog2(FifoDepth + 1);
  localparam int RndW = (NumRounds > 1) ? $clog2(NumRounds) : 1;

  typedef enum logic {
    ST_IDLE,
    ST_RUN
  } engine_state_e;

  shell_cmd_t      fifo_mem [FifoDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] fifo_cnt_q;
  shell_cmd_t      head;
  logic            pop;

  engine_state_e   state_q;
  shell_op_e       run_op_q;
  logic [RndW-1:0] round_q;
  logic            last_round;
  logic [7:0]      work_q;
  logic [7:0]      mixed;
  logic [7:0]      work_next;
  logic [7:0]      key_q;
  logic [7:0]      result_q;
  logic            trig_req_q;

  function automatic logic [PtrW-1:0] ptr_inc(logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(FifoDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////
  // Command queue
  ////////////////////

  assign head = fifo_mem[rd_ptr_q];

  // One command leaves per idle cycle, and its credit goes back at once
  assign pop             = (state_q == ST_IDLE) && (fifo_cnt_q != '0);
  assign credit_return_o = pop;

  always_ff @(posedge clk_main_i) begin
    if (cmd_valid_i) begin
      fifo_mem[wr_ptr_q] <= cmd_i;
    end
  end

  always_ff @(posedge clk_main_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      if (cmd_valid_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({cmd_valid_i, pop})
        2'b10:   fifo_cnt_q <= fifo_cnt_q + 1'b1;
        2'b01:   fifo_cnt_q <= fifo_cnt_q - 1'b1;
        default: fifo_cnt_q <= fifo_cnt_q;
      endcase
    end
  end

  ////////////////////
  // Round function
  ////////////////////

  // XOR with key, then rotate left by one
  assign mixed      = work_q ^ key_q;
  assign work_next  = {mixed[6:0], mixed[7]};
  assign last_round = (round_q == RndW'(NumRounds - 1));

  always_ff @(posedge clk_main_i) begin
    if (pop) begin
      work_q <= head.data;
    end else if (state_q == ST_RUN) begin
      work_q <= work_next;
    end
  end

  ////////////////////
  // Control FSM
  ////////////////////

  always_ff @(posedge clk_main_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= ST_IDLE;
      run_op_q   <= OP_ARM;
      round_q    <= '0;
      key_q      <= '0;
      result_q   <= '0;
      trig_req_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (pop) begin
            case (head.op)
              OP_ARM: trig_req_q <= ~trig_req_q;
              OP_KEY: key_q <= head.data;
              default: begin
                // Scramble and clear both take the multi-round path
                state_q  <= ST_RUN;
                run_op_q <= head.op;
                round_q  <= '0;
              end
            endcase
          end
        end
        ST_RUN: begin
          round_q <= round_q + 1'b1;
          if (last_round) begin
            state_q <= ST_IDLE;
            if (run_op_q == OP_CLEAR) begin
              key_q    <= '0;
              result_q <= '0;
            end else begin
              result_q <= work_next;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign result_o   = result_q;
  assign busy_o     = (state_q == ST_RUN);
  assign trig_req_o = trig_req_q;

endmodule : scramble_engine
